/* logic/agen_pkg.sv */
/*
 * address generation package
 * widths, source and size encodings, and the pipe payload width
 */
package agen_pkg;

    localparam int GPR_W     = 32;
    localparam int SEG_W     = 16;
    localparam int OPERAND_W = 64;
    localparam int IMM_W     = 48;
    localparam int ALU_OP_W  = 4;
    localparam int PC_W      = 32;

    // segment base is the selector times 16
    localparam int SEG_SHIFT = 4;

    // operand source, as decoded upstream
    typedef enum logic [2:0] {
        NONE  = 3'd0,
        REG   = 3'd1,
        SEG   = 3'd2,
        MMX   = 3'd3,
        MODRM = 3'd4,
        IMM   = 3'd5,
        MEM   = 3'd6,
        SYS   = 3'd7
    } op_src_e;

    // other encodings give a zero register view
    typedef enum logic [2:0] {
        SZ8  = 3'd1,
        SZ16 = 3'd2,
        SZ32 = 3'd3
    } size_e;

    // at SZ8 indices 4..7 are AH, CH, DH, BH
    typedef enum logic [2:0] {
        EAX, ECX, EDX, EBX, ESP, EBP, ESI, EDI
    } reg_idx_e;

    // 6 and 7 have no segment
    typedef enum logic [2:0] {
        ES, CS, SS, DS, FS, GS
    } seg_e;

    // size, two operands, two indices, two address flags, alu op, pc, sys flag
    localparam int PIPE_W = 3 + 2 * OPERAND_W + 3 + 3 + 2 + ALU_OP_W + PC_W + 1;

endpackage

/* logic/reg_size_selector.sv */
/*
 * register size selector
 * views the eight general registers at the requested operand size
 */
`timescale 1ns/1ps

module reg_size_selector import agen_pkg::*; (
    input  size_e                 size,
    input  logic [GPR_W-1:0]      eax,
    input  logic [GPR_W-1:0]      ecx,
    input  logic [GPR_W-1:0]      edx,
    input  logic [GPR_W-1:0]      ebx,
    input  logic [GPR_W-1:0]      esp,
    input  logic [GPR_W-1:0]      ebp,
    input  logic [GPR_W-1:0]      esi,
    input  logic [GPR_W-1:0]      edi,
    output logic [OPERAND_W-1:0]  reg_0,
    output logic [OPERAND_W-1:0]  reg_1,
    output logic [OPERAND_W-1:0]  reg_2,
    output logic [OPERAND_W-1:0]  reg_3,
    output logic [OPERAND_W-1:0]  reg_4,
    output logic [OPERAND_W-1:0]  reg_5,
    output logic [OPERAND_W-1:0]  reg_6,
    output logic [OPERAND_W-1:0]  reg_7
);

    always_comb begin
        reg_0 = '0;
        reg_1 = '0;
        reg_2 = '0;
        reg_3 = '0;
        reg_4 = '0;
        reg_5 = '0;
        reg_6 = '0;
        reg_7 = '0;
        case (size)
            SZ8: begin
                reg_0 = OPERAND_W'(eax[7:0]);
                reg_1 = OPERAND_W'(ecx[7:0]);
                reg_2 = OPERAND_W'(edx[7:0]);
                reg_3 = OPERAND_W'(ebx[7:0]);
                // high bytes of the first four registers
                reg_4 = OPERAND_W'(eax[15:8]);
                reg_5 = OPERAND_W'(ecx[15:8]);
                reg_6 = OPERAND_W'(edx[15:8]);
                reg_7 = OPERAND_W'(ebx[15:8]);
            end
            SZ16: begin
                reg_0 = OPERAND_W'(eax[15:0]);
                reg_1 = OPERAND_W'(ecx[15:0]);
                reg_2 = OPERAND_W'(edx[15:0]);
                reg_3 = OPERAND_W'(ebx[15:0]);
                reg_4 = OPERAND_W'(esp[15:0]);
                reg_5 = OPERAND_W'(ebp[15:0]);
                reg_6 = OPERAND_W'(esi[15:0]);
                reg_7 = OPERAND_W'(edi[15:0]);
            end
            SZ32: begin
                reg_0 = OPERAND_W'(eax);
                reg_1 = OPERAND_W'(ecx);
                reg_2 = OPERAND_W'(edx);
                reg_3 = OPERAND_W'(ebx);
                reg_4 = OPERAND_W'(esp);
                reg_5 = OPERAND_W'(ebp);
                reg_6 = OPERAND_W'(esi);
                reg_7 = OPERAND_W'(edi);
            end
            default: begin
                // unsupported size, all views stay zero
            end
        endcase
    end

endmodule

/* logic/string_address_gen.sv */
/*
 * string address generator
 * forms the ES:EDI and DS:ESI linear addresses, with segment override on DS
 */
`timescale 1ns/1ps

module string_address_gen import agen_pkg::*; (
    input  logic [SEG_W-1:0]  es,
    input  logic [SEG_W-1:0]  cs,
    input  logic [SEG_W-1:0]  ss,
    input  logic [SEG_W-1:0]  ds,
    input  logic [SEG_W-1:0]  fs,
    input  logic [SEG_W-1:0]  gs,
    input  logic [GPR_W-1:0]  edi,
    input  logic [GPR_W-1:0]  esi,
    input  seg_e              seg_override,
    input  logic              seg_override_valid,
    output logic [GPR_W-1:0]  es_edi_addr,
    output logic [GPR_W-1:0]  ds_esi_addr
);

    logic [SEG_W-1:0] override_seg;
    logic [SEG_W-1:0] src_seg;

    always_comb begin
        case (seg_override)
            ES:      override_seg = es;
            CS:      override_seg = cs;
            SS:      override_seg = ss;
            DS:      override_seg = ds;
            FS:      override_seg = fs;
            GS:      override_seg = gs;
            default: override_seg = '0;
        endcase
    end

    assign src_seg = seg_override_valid ? override_seg : ds;

    // 32 bit sums, carry out is dropped
    assign es_edi_addr = (GPR_W'(es) << SEG_SHIFT) + edi;
    assign ds_esi_addr = (GPR_W'(src_seg) << SEG_SHIFT) + esi;

endmodule

/* logic/operand_generator.sv */
/*
 * operand generator
 * picks one operand from register, segment, immediate or string address
 * and flags it when it is a memory address
 */
`timescale 1ns/1ps

module operand_generator import agen_pkg::*; (
    input  op_src_e                src,
    input  reg_idx_e               reg_idx,
    input  logic [OPERAND_W-1:0]   reg_0,
    input  logic [OPERAND_W-1:0]   reg_1,
    input  logic [OPERAND_W-1:0]   reg_2,
    input  logic [OPERAND_W-1:0]   reg_3,
    input  logic [OPERAND_W-1:0]   reg_4,
    input  logic [OPERAND_W-1:0]   reg_5,
    input  logic [OPERAND_W-1:0]   reg_6,
    input  logic [OPERAND_W-1:0]   reg_7,
    input  logic [SEG_W-1:0]       es,
    input  logic [SEG_W-1:0]       cs,
    input  logic [SEG_W-1:0]       ss,
    input  logic [SEG_W-1:0]       ds,
    input  logic [SEG_W-1:0]       fs,
    input  logic [SEG_W-1:0]       gs,
    input  logic [IMM_W-1:0]       imm,
    input  logic [GPR_W-1:0]       mem_addr,
    output logic [OPERAND_W-1:0]   operand,
    output logic                   is_address
);

    logic [OPERAND_W-1:0] reg_view;
    logic [SEG_W-1:0]     seg_view;

    // register view, already sized
    always_comb begin
        case (reg_idx)
            EAX:     reg_view = reg_0;
            ECX:     reg_view = reg_1;
            EDX:     reg_view = reg_2;
            EBX:     reg_view = reg_3;
            ESP:     reg_view = reg_4;
            EBP:     reg_view = reg_5;
            ESI:     reg_view = reg_6;
            EDI:     reg_view = reg_7;
            default: reg_view = '0;
        endcase
    end

    // reg_idx doubles as the segment number
    always_comb begin
        case (seg_e'(reg_idx))
            ES:      seg_view = es;
            CS:      seg_view = cs;
            SS:      seg_view = ss;
            DS:      seg_view = ds;
            FS:      seg_view = fs;
            GS:      seg_view = gs;
            default: seg_view = '0;
        endcase
    end

    always_comb begin
        case (src)
            REG:     operand = reg_view;
            SEG:     operand = OPERAND_W'(seg_view);
            IMM:     operand = OPERAND_W'(imm);
            MEM:     operand = OPERAND_W'(mem_addr);
            // mmx, mod r/m and sys have no operand here
            NONE, MMX, MODRM, SYS: operand = '0;
            default: operand = '0;
        endcase
    end

    assign is_address = (src == MEM);

endmodule

/* logic/pipe_stage.sv */
/*
 * pipe stage
 * one-entry valid/ready register, emptied by flush or reset
 */
`timescale 1ns/1ps

module pipe_stage import agen_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               in_valid,
    output logic               in_ready,
    input  logic [PIPE_W-1:0]  in_data,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [PIPE_W-1:0]  out_data
);

    logic load;

    // free slot, or the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready && !flush;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

/* logic/address_generation_top.sv */
/*
 * address generation stage
 * forms both operands from the register access snapshot and registers
 * them, with the pass-through fields, into a valid/ready pipe stage
 */
`timescale 1ns/1ps

module address_generation_top import agen_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,

    // from register access
    input  logic                  r_valid,
    output logic                  r_ready,
    input  size_e                 r_size,
    input  op_src_e               r_op0,
    input  op_src_e               r_op1,
    input  reg_idx_e              r_op0_reg,
    input  reg_idx_e              r_op1_reg,
    input  logic [IMM_W-1:0]      r_imm,
    input  logic [ALU_OP_W-1:0]   r_alu_op,
    input  seg_e                  r_seg_override,
    input  logic                  r_seg_override_valid,
    input  logic [GPR_W-1:0]      r_eax,
    input  logic [GPR_W-1:0]      r_ecx,
    input  logic [GPR_W-1:0]      r_edx,
    input  logic [GPR_W-1:0]      r_ebx,
    input  logic [GPR_W-1:0]      r_esp,
    input  logic [GPR_W-1:0]      r_ebp,
    input  logic [GPR_W-1:0]      r_esi,
    input  logic [GPR_W-1:0]      r_edi,
    input  logic [SEG_W-1:0]      r_cs,
    input  logic [SEG_W-1:0]      r_ds,
    input  logic [SEG_W-1:0]      r_es,
    input  logic [SEG_W-1:0]      r_fs,
    input  logic [SEG_W-1:0]      r_gs,
    input  logic [SEG_W-1:0]      r_ss,
    input  logic [PC_W-1:0]       r_pc,

    // to memory access
    output logic                  a_valid,
    input  logic                  a_ready,
    output size_e                 a_size,
    output logic [OPERAND_W-1:0]  a_op0,
    output logic [OPERAND_W-1:0]  a_op1,
    output reg_idx_e              a_op0_reg,
    output reg_idx_e              a_op1_reg,
    output logic                  a_op0_is_address,
    output logic                  a_op1_is_address,
    output logic [ALU_OP_W-1:0]   a_alu_op,
    output logic [PC_W-1:0]       a_pc,
    output logic                  a_to_sys_controller
);

    logic [OPERAND_W-1:0] reg_0, reg_1, reg_2, reg_3;
    logic [OPERAND_W-1:0] reg_4, reg_5, reg_6, reg_7;
    logic [GPR_W-1:0]     es_edi_addr;
    logic [GPR_W-1:0]     ds_esi_addr;
    logic [OPERAND_W-1:0] p_op0, p_op1;
    logic                 p_op0_is_address, p_op1_is_address;
    logic                 p_to_sys;
    logic [PIPE_W-1:0]    pipe_in_data, pipe_out_data;
    logic [2:0]           q_size, q_op0_reg, q_op1_reg;

    reg_size_selector u_size_sel (
        .size(r_size),
        .eax(r_eax), .ecx(r_ecx), .edx(r_edx), .ebx(r_ebx),
        .esp(r_esp), .ebp(r_ebp), .esi(r_esi), .edi(r_edi),
        .reg_0(reg_0), .reg_1(reg_1), .reg_2(reg_2), .reg_3(reg_3),
        .reg_4(reg_4), .reg_5(reg_5), .reg_6(reg_6), .reg_7(reg_7)
    );

    string_address_gen u_str_addr (
        .es(r_es), .cs(r_cs), .ss(r_ss), .ds(r_ds), .fs(r_fs), .gs(r_gs),
        .edi(r_edi),
        .esi(r_esi),
        .seg_override(r_seg_override),
        .seg_override_valid(r_seg_override_valid),
        .es_edi_addr(es_edi_addr),
        .ds_esi_addr(ds_esi_addr)
    );

    // op0 strings are always ES:EDI
    operand_generator u_op0_gen (
        .src(r_op0), .reg_idx(r_op0_reg),
        .reg_0(reg_0), .reg_1(reg_1), .reg_2(reg_2), .reg_3(reg_3),
        .reg_4(reg_4), .reg_5(reg_5), .reg_6(reg_6), .reg_7(reg_7),
        .es(r_es), .cs(r_cs), .ss(r_ss), .ds(r_ds), .fs(r_fs), .gs(r_gs),
        .imm(r_imm), .mem_addr(es_edi_addr),
        .operand(p_op0), .is_address(p_op0_is_address)
    );

    operand_generator u_op1_gen (
        .src(r_op1), .reg_idx(r_op1_reg),
        .reg_0(reg_0), .reg_1(reg_1), .reg_2(reg_2), .reg_3(reg_3),
        .reg_4(reg_4), .reg_5(reg_5), .reg_6(reg_6), .reg_7(reg_7),
        .es(r_es), .cs(r_cs), .ss(r_ss), .ds(r_ds), .fs(r_fs), .gs(r_gs),
        .imm(r_imm), .mem_addr(ds_esi_addr),
        .operand(p_op1), .is_address(p_op1_is_address)
    );

    // registered with the payload
    assign p_to_sys = (r_op0 == SYS);

    assign pipe_in_data = {r_size, p_op0, p_op1, r_op0_reg, r_op1_reg,
                           p_op0_is_address, p_op1_is_address,
                           r_alu_op, r_pc, p_to_sys};

    pipe_stage u_pipe (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .in_valid(r_valid), .in_ready(r_ready), .in_data(pipe_in_data),
        .out_valid(a_valid), .out_ready(a_ready), .out_data(pipe_out_data)
    );

    assign {q_size, a_op0, a_op1, q_op0_reg, q_op1_reg,
            a_op0_is_address, a_op1_is_address,
            a_alu_op, a_pc, a_to_sys_controller} = pipe_out_data;

    assign a_size    = size_e'(q_size);
    assign a_op0_reg = reg_idx_e'(q_op0_reg);
    assign a_op1_reg = reg_idx_e'(q_op1_reg);

endmodule

/* testbench/agen_properties.sv */
/*
 * handshake assertions for the pipe stage, bound to every instance
 */
`timescale 1ns/1ps

module agen_properties import agen_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic              in_ready,
    input logic              out_valid,
    input logic              out_ready,
    input logic [PIPE_W-1:0] out_data
);

    // empty on the cycle after reset
    a_reset_empty: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high after reset");

    // a stalled item keeps its payload
    a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_data))
        else $error("out_data changed while stalled");

    a_stall_blocks: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |-> !in_ready)
        else $error("in_ready high while stalled");

endmodule

bind pipe_stage agen_properties u_props (
    .clk(clk), .rst_n(rst_n), .in_ready(in_ready),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
);

/* testbench/tb_address_generation.sv */
/*
 * testbench for the address generation stage
 * random register snapshots, checked against a reference model through the pipe
 */
`timescale 1ns/1ps

module tb_address_generation import agen_pkg::*; ();

    // tests times largest item count times cycles per item, plus margin
    localparam int WATCHDOG_CYCLES = 6 * 64 * 40 + 500;

    logic                  clk, rst_n, flush;
    logic                  r_valid, r_ready, a_valid, a_ready;
    size_e                 r_size, a_size;
    op_src_e               r_op0, r_op1;
    reg_idx_e              r_op0_reg, r_op1_reg, a_op0_reg, a_op1_reg;
    seg_e                  r_seg_override;
    logic                  r_seg_override_valid;
    logic [IMM_W-1:0]      r_imm;
    logic [ALU_OP_W-1:0]   r_alu_op, a_alu_op;
    logic [PC_W-1:0]       r_pc, a_pc;
    logic [GPR_W-1:0]      gpr [8];
    // ES, CS, SS, DS, FS, GS
    logic [SEG_W-1:0]      seg [6];
    logic [OPERAND_W-1:0]  a_op0, a_op1;
    logic                  a_op0_is_address, a_op1_is_address, a_to_sys_controller;
    logic [PIPE_W-1:0]     act, expv, held_act;
    logic [PIPE_W-1:0]     exp_q [$];
    logic                  stalled = 1'b0;
    logic                  bp_mode, stall_all;
    logic [31:0]           rnd;
    integer                seed = 69;
    integer                ready_seed = 69;
    int                    errors = 0;
    int                    checks = 0;
    string                 cur_test = "reset";

    address_generation_top u_dut (
        .r_eax(gpr[0]), .r_ecx(gpr[1]), .r_edx(gpr[2]), .r_ebx(gpr[3]),
        .r_esp(gpr[4]), .r_ebp(gpr[5]), .r_esi(gpr[6]), .r_edi(gpr[7]),
        .r_es(seg[0]), .r_cs(seg[1]), .r_ss(seg[2]), .r_ds(seg[3]),
        .r_fs(seg[4]), .r_gs(seg[5]),
        .*
    );

    assign act = {a_size, a_op0, a_op1, a_op0_reg, a_op1_reg, a_op0_is_address,
                  a_op1_is_address, a_alu_op, a_pc, a_to_sys_controller};

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    // downstream ready, random under back-pressure
    initial begin
        a_ready <= 1'b1;
        forever begin
            @(posedge clk);
            rnd = $random(ready_seed);
            a_ready <= !stall_all && (!bp_mode || rnd[0]);
        end
    end

    // AH..BH are bits 15:8 of the first four registers
    function automatic logic [OPERAND_W-1:0] gpr_view(input logic [2:0] sz,
                                                      input logic [2:0] idx);
        case (sz)
            3'd1: return idx[2] ? OPERAND_W'(gpr[{1'b0, idx[1:0]}][15:8])
                                : OPERAND_W'(gpr[idx][7:0]);
            3'd2: return OPERAND_W'(gpr[idx][15:0]);
            3'd3: return OPERAND_W'(gpr[idx]);
            default: return '0;
        endcase
    endfunction

    function automatic logic [OPERAND_W-1:0] src_value(input op_src_e src,
                                                       input logic [2:0] idx,
                                                       input logic [GPR_W-1:0] addr);
        case (src)
            REG: return gpr_view(r_size, idx);
            SEG: return (idx < 3'd6) ? OPERAND_W'(seg[idx]) : '0;
            IMM: return OPERAND_W'(r_imm);
            MEM: return OPERAND_W'(addr);
            default: return '0;
        endcase
    endfunction

    // expected a_ outputs, same field order as act
    function automatic logic [PIPE_W-1:0] agen_model();
        logic [SEG_W-1:0] si_seg;
        logic [GPR_W-1:0] di_addr;
        logic [GPR_W-1:0] si_addr;
        si_seg = seg[3];
        if (r_seg_override_valid) begin
            si_seg = (r_seg_override < 3'd6) ? seg[r_seg_override] : '0;
        end
        // segment times 16 plus offset, 32 bit wrap
        di_addr = {12'b0, seg[0], 4'b0} + gpr[7];
        si_addr = {12'b0, si_seg, 4'b0} + gpr[6];
        return {r_size, src_value(r_op0, r_op0_reg, di_addr),
                src_value(r_op1, r_op1_reg, si_addr), r_op0_reg, r_op1_reg,
                r_op0 == MEM, r_op1 == MEM, r_alu_op, r_pc, r_op0 == SYS};
    endfunction

    // random snapshot, then the fields each test pins down
    task automatic drive_fields(input int kind, input int i);
        logic [31:0] r;
        foreach (gpr[k]) begin
            gpr[k] <= $random(seed);
        end
        foreach (seg[k]) begin
            r = $random(seed);
            seg[k] <= r[15:0];
        end
        r = $random(seed);
        r_size <= size_e'(r[2:0]);
        r_op0 <= op_src_e'(r[5:3]);
        r_op1 <= op_src_e'(r[8:6]);
        r_op0_reg <= reg_idx_e'(r[11:9]);
        r_op1_reg <= reg_idx_e'(r[14:12]);
        r_seg_override <= seg_e'(r[17:15]);
        r_seg_override_valid <= r[18];
        r_alu_op <= r[22:19];
        r_imm <= {r[31:16], 32'($random(seed))};
        r_pc <= $random(seed);
        case (kind)
            0: begin
                // every size against every index
                r_size <= size_e'(i[5:3]);
                r_op0 <= REG;
                r_op1 <= REG;
                r_op0_reg <= reg_idx_e'(i[2:0]);
                r_op1_reg <= reg_idx_e'(~i[2:0]);
            end
            1: begin
                case (i % 5)
                    0: r_op0 <= NONE;
                    1: r_op0 <= SEG;
                    2: r_op0 <= MMX;
                    3: r_op0 <= MODRM;
                    default: r_op0 <= IMM;
                endcase
                r_op1 <= i[0] ? SEG : IMM;
                r_op0_reg <= reg_idx_e'(i[2:0]);
            end
            2: begin
                r_op0 <= MEM;
                r_op1 <= MEM;
                r_seg_override_valid <= i[3];
                r_seg_override <= seg_e'(i[2:0]);
                if (i[1:0] == 2'd0) begin
                    // near the top of the address space, both sums wrap
                    foreach (seg[k]) begin
                        seg[k] <= 16'hffff;
                    end
                    gpr[6] <= 32'hffff_ff80;
                    gpr[7] <= 32'hffff_ff80;
                end
            end
            3: begin
                if (i[1:0] == 2'd0) begin
                    r_op0 <= SYS;
                end
            end
            default: ;
        endcase
    endtask

    task automatic send_item(input int kind, input int i);
        @(posedge clk);
        drive_fields(kind, i);
        r_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!r_ready);
        r_valid <= 1'b0;
    endtask

    task automatic drain();
        do begin
            @(negedge clk);
        end while (exp_q.size() != 0 || a_valid);
    endtask

    task automatic run_test(input string name, input int kind, input int n);
        int err0;
        int i;
        err0 = errors;
        cur_test = name;
        @(posedge clk);
        bp_mode <= (kind == 4);
        for (i = 0; i < n; i++) begin
            send_item(kind, i);
        end
        drain();
        $display("test %s: %0d items, %0d errors", name, n, errors - err0);
    endtask

    // hold one item, flush while a second is offered, flush again with the
    // register empty and a third offered, then run normally
    task automatic run_flush();
        int err0;
        int i;
        err0 = errors;
        cur_test = "flush";
        @(posedge clk);
        bp_mode <= 1'b0;
        stall_all <= 1'b1;
        send_item(5, 0);
        @(posedge clk);
        drive_fields(5, 1);
        r_valid <= 1'b1;
        flush <= 1'b1;
        @(posedge clk);
        // slot is empty now, so this offer meets r_ready high
        drive_fields(5, 2);
        stall_all <= 1'b0;
        @(posedge clk);
        r_valid <= 1'b0;
        flush <= 1'b0;
        for (i = 3; i < 9; i++) begin
            send_item(5, i);
        end
        drain();
        $display("test flush: 9 items, %0d errors", errors - err0);
    endtask

    // scoreboard, queue follows both handshakes and the flush
    always @(posedge clk) begin
        if (rst_n) begin
            if (a_valid && a_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("an item came out in test %s with none pending", cur_test);
                end else begin
                    expv = exp_q.pop_front();
                    checks++;
                    if (act != expv) begin
                        errors++;
                        $display("error %s: expected %h, actual %h", cur_test, expv, act);
                    end
                end
            end
            if (stalled && a_valid && act != held_act) begin
                errors++;
                $display("outputs changed during a stall in test %s", cur_test);
            end
            stalled = a_valid && !a_ready;
            held_act = act;
            if (flush) begin
                exp_q.delete();
            end else if (r_valid && r_ready) begin
                exp_q.push_back(agen_model());
            end
        end
    end

    initial begin
        rst_n <= 1'b0;
        flush <= 1'b0;
        r_valid <= 1'b0;
        bp_mode <= 1'b0;
        stall_all <= 1'b0;
        drive_fields(3, 1);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        run_test("register", 0, 64);
        run_test("seg_imm", 1, 40);
        run_test("string", 2, 32);
        run_test("sys_flag", 3, 32);
        run_test("backpressure", 4, 48);
        run_flush();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/agen_pkg.sv
logic/reg_size_selector.sv
logic/string_address_gen.sv
logic/operand_generator.sv
logic/pipe_stage.sv
logic/address_generation_top.sv
testbench/agen_properties.sv
testbench/tb_address_generation.sv

/* run.sh */
#!/bin/sh
# build the address generation testbench with Verilator and run it
cd "$(dirname "$0")" &&
    verilator --binary --assert -j 0 --top-module tb_address_generation -f flist.f &&
    ./obj_dir/Vtb_address_generation | tee /dev/stderr | grep -q "Everything OK" ||
    { echo "simulation failed"; exit 1; }
echo "simulation passed"
